/* mem_sub.f */
+incdir+common
common/cpu_req_pkg.sv
common/bus_pkg.sv
common/mem_bus_if.sv
mem/mem_access.sv
src/word_ram.sv
src/mem_top.sv
tb/mem_tb.sv

/* tb/mem_tb.sv */
/*
  table driven testbench for the memory subsystem
  a shadow byte memory gives the expected read data, cen is throttled randomly
  all addresses stay below 0x2000, the decoded RAM range
*/
`timescale 1ns/100ps
`include "mem_defs.svh"

module mem_tb
    import cpu_req_pkg::*, bus_pkg::*;
();

    typedef enum logic [1:0] {
        OP_WRITE   = 2'd0,
        OP_READ    = 2'd1,
        OP_LOAD_EA = 2'd2   // da2ea pulse, no request
    } op_t;

    typedef struct packed {
        op_t                op;
        acc_size_t          size;
        ea_src_t            src;
        logic [`ADDR_W-1:0] pc;
        logic [`ADDR_W-1:0] da;
        logic [`ADDR_W-1:0] xsp;
        logic [31:0]        wdata;
        logic [`ADDR_W-1:0] exp_ea;
    } row_t;

    logic               clk;
    logic               rst;
    logic               cen;
    logic               req;
    logic               wr;
    acc_size_t          size;
    ea_src_t            src;
    logic               da2ea;
    logic [`ADDR_W-1:0] pc;
    logic [`ADDR_W-1:0] da;
    logic [`ADDR_W-1:0] xsp;
    logic [31:0]        wdata32;
    logic [`ADDR_W-1:0] ea;
    logic [31:0]        mdata;
    logic               busy;

    row_t               rows[$];
    logic [7:0]         shadow [0:8191];   // byte image of the RAM
    logic [`ADDR_W-1:0] cached;            // model of the cached read address
    logic [`ADDR_W-1:0] model_ea;
    logic [31:0]        last_mdata;
    logic [31:0]        lfsr;

    mem_top UUT (
        .clk     (clk),
        .rst     (rst),
        .cen     (cen),
        .req     (req),
        .wr      (wr),
        .size    (size),
        .src     (src),
        .da2ea   (da2ea),
        .pc      (pc),
        .da      (da),
        .xsp     (xsp),
        .wdata32 (wdata32),
        .ea      (ea),
        .mdata   (mdata),
        .busy    (busy)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        // taps 32 22 2 1
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bit(output logic b);
        b    = lfsr[0];
        lfsr = lfsr_next(lfsr);
    endtask

    // cen high about three cycles in four
    initial begin
        logic b0;
        logic b1;
        lfsr = 32'ha38c_38d6;
        cen  = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            take_bit(b0);
            take_bit(b1);
            cen = !(b0 && b1);
        end
    end

    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                               input string msg);
        bus_phase_t ph;
        ph = UUT.u_access.phase;
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s, got %h expected %h, phase %s",
                     $time, msg, got, exp, ph.name());
            $display("Test FAILED");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // cen qualified edges from acceptance until busy is low again
    function automatic int access_edges(input logic is_wr, input acc_size_t sz,
                                        input logic odd);
        if (!is_wr)
            return odd ? 4 : 3;
        case (sz)
            SZ_BYTE: return 1;
            SZ_WORD: return odd ? 2 : 1;
            default: return odd ? 3 : 2;
        endcase
    endfunction

    function automatic logic [31:0] shadow_quad(input logic [`ADDR_W-1:0] a);
        return {shadow[a + 3], shadow[a + 2], shadow[a + 1], shadow[a]};
    endfunction

    // unused address fields get decoys so a wrong source shows up
    task automatic add_access(input op_t op, input acc_size_t sz, input ea_src_t s,
                              input logic [`ADDR_W-1:0] a, input logic [31:0] d,
                              input logic [`ADDR_W-1:0] exp_ea);
        row_t r;
        r.op     = op;
        r.size   = sz;
        r.src    = s;
        r.pc     = (s == SRC_PC) ? a : a + 24'h0400;
        r.da     = (s == SRC_DA) ? a : a + 24'h0800;
        r.xsp    = (s == SRC_SP) ? a : a + 24'h0c00;
        r.wdata  = d;
        r.exp_ea = exp_ea;
        rows.push_back(r);
    endtask

    task automatic add_load(input logic [`ADDR_W-1:0] a, input logic [`ADDR_W-1:0] exp_ea);
        row_t r;
        r.op     = OP_LOAD_EA;
        r.size   = SZ_BYTE;
        r.src    = SRC_PC;
        r.pc     = a + 24'h0400;
        r.da     = a;
        r.xsp    = a + 24'h0c00;
        r.wdata  = 32'h0;
        r.exp_ea = exp_ea;
        rows.push_back(r);
    endtask

    task automatic build_table();
        add_access(OP_WRITE, SZ_QUAD, SRC_PC, 24'h0100, 32'h0302_0100, 24'h0);
        add_access(OP_WRITE, SZ_QUAD, SRC_DA, 24'h0104, 32'h0706_0504, 24'h0);
        add_access(OP_WRITE, SZ_QUAD, SRC_SP, 24'h0108, 32'h0b0a_0908, 24'h0);
        add_access(OP_WRITE, SZ_QUAD, SRC_PC, 24'h010c, 32'h0f0e_0d0c, 24'h0);
        add_access(OP_READ,  SZ_QUAD, SRC_PC, 24'h0100, 32'h0,         24'h0);
        add_access(OP_READ,  SZ_QUAD, SRC_PC, 24'h0100, 32'h0,         24'h0);  // skipped
        add_access(OP_WRITE, SZ_BYTE, SRC_DA, 24'h0101, 32'h5e5e_5ea1, 24'h0);
        add_access(OP_READ,  SZ_QUAD, SRC_PC, 24'h0100, 32'h0,         24'h0);  // after write
        add_access(OP_WRITE, SZ_BYTE, SRC_SP, 24'h0104, 32'h6d6d_6db4, 24'h0);
        add_access(OP_WRITE, SZ_WORD, SRC_DA, 24'h0106, 32'h7777_c7c6, 24'h0);
        add_access(OP_WRITE, SZ_WORD, SRC_PC, 24'h0109, 32'h8888_d2d1, 24'h0);
        add_access(OP_WRITE, SZ_QUAD, SRC_SP, 24'h010d, 32'he4e3_e2e1, 24'h0);
        add_access(OP_WRITE, SZ_QUAD, SRC_DA, 24'h0103, 32'hf4f3_f2f1, 24'h0);
        add_access(OP_READ,  SZ_QUAD, SRC_SP, 24'h0103, 32'h0,         24'h0);
        add_access(OP_READ,  SZ_QUAD, SRC_DA, 24'h0108, 32'h0,         24'h0);
        add_access(OP_READ,  SZ_QUAD, SRC_PC, 24'h010b, 32'h0,         24'h0);
        add_access(OP_READ,  SZ_QUAD, SRC_SP, 24'h010d, 32'h0,         24'h0);
        add_access(OP_READ,  SZ_QUAD, SRC_DA, 24'h0104, 32'h0,         24'h0);
        add_load(24'h0109, 24'h0109);
        add_access(OP_READ,  SZ_QUAD, SRC_EA, 24'h0109, 32'h0,         24'h0109);
        add_access(OP_READ,  SZ_QUAD, SRC_EA, 24'h0109, 32'h0,         24'h0109);
        add_access(OP_WRITE, SZ_WORD, SRC_EA, 24'h0109, 32'h1234_5a5b, 24'h0109);
        add_access(OP_READ,  SZ_QUAD, SRC_EA, 24'h0109, 32'h0,         24'h0109);
        add_load(24'h0100, 24'h0100);
        add_access(OP_WRITE, SZ_BYTE, SRC_EA, 24'h0100, 32'hcafe_ba77, 24'h0100);
        add_access(OP_READ,  SZ_QUAD, SRC_EA, 24'h0100, 32'h0,         24'h0100);
        add_access(OP_READ,  SZ_QUAD, SRC_PC, 24'h0100, 32'h0,         24'h0100);  // same addr
        add_access(OP_READ,  SZ_QUAD, SRC_DA, 24'h0101, 32'h0,         24'h0100);
        add_access(OP_WRITE, SZ_BYTE, SRC_PC, 24'h0111, 32'h4242_4299, 24'h0100);
        add_access(OP_READ,  SZ_QUAD, SRC_SP, 24'h010e, 32'h0,         24'h0100);
        add_access(OP_READ,  SZ_QUAD, SRC_SP, 24'h010e, 32'h0,         24'h0100);
    endtask

    // holds the strobe until an edge with cen high takes it
    task automatic wait_accept();
        do begin
            @(posedge clk);
        end while (cen !== 1'b1);
    endtask

    task automatic run_row(input int idx, input row_t r);
        logic [`ADDR_W-1:0] addr;
        logic               skip;
        int                 edges;
        int                 nbytes;
        case (r.src)
            SRC_PC:  addr = r.pc;
            SRC_DA:  addr = r.da;
            SRC_SP:  addr = r.xsp;
            default: addr = model_ea;
        endcase
        skip    = (r.op == OP_READ) && (addr == cached);
        pc      = r.pc;
        da      = r.da;
        xsp     = r.xsp;
        size    = r.size;
        src     = r.src;
        wdata32 = r.wdata;
        wr      = (r.op == OP_WRITE);
        if (r.op == OP_LOAD_EA)
            da2ea = 1'b1;
        else
            req = 1'b1;
        wait_accept();
        #1;
        req   = 1'b0;
        da2ea = 1'b0;
        if (r.op == OP_LOAD_EA) begin
            model_ea = r.da;
        end else if (skip) begin
            check_equal(busy, 1'b0, $sformatf("row %0d busy on skipped read", idx));
            check_equal(mdata, last_mdata, $sformatf("row %0d mdata after skip", idx));
        end else begin
            check_equal(busy, 1'b1, $sformatf("row %0d busy after accept", idx));
            edges = 0;
            while (busy === 1'b1) begin
                @(posedge clk);
                if (cen === 1'b1)
                    edges++;
                #1;
            end
            check_equal(edges, access_edges(r.op == OP_WRITE, r.size, addr[0]),
                        $sformatf("row %0d access length in cen edges", idx));
            if (r.op == OP_WRITE) begin
                nbytes = (r.size == SZ_BYTE) ? 1 : (r.size == SZ_WORD) ? 2 : 4;
                for (int k = 0; k < nbytes; k++)
                    shadow[addr + k] = r.wdata[8*k +: 8];
                cached = '1;    // write drops the cached read
            end else begin
                cached = addr;
                check_equal(mdata, shadow_quad(addr),
                            $sformatf("row %0d read data at %h", idx, addr));
                last_mdata = shadow_quad(addr);
            end
        end
        check_equal(ea, r.exp_ea, $sformatf("row %0d ea", idx));
    endtask

    initial begin
        rst        = 1'b1;
        req        = 1'b0;
        wr         = 1'b0;
        size       = SZ_BYTE;
        src        = SRC_PC;
        da2ea      = 1'b0;
        pc         = '0;
        da         = '0;
        xsp        = '0;
        wdata32    = '0;
        cached     = '1;
        model_ea   = '0;
        last_mdata = '0;
        build_table();
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        check_equal(busy, 1'b0, "busy after reset");
        check_equal(ea, 24'h0, "ea after reset");
        check_equal(mdata, 32'h0, "mdata after reset");
        foreach (rows[i])
            run_row(i, rows[i]);
        $display("Test OK");
        $finish;
    end

    // generous bound, 40 cycles per table row
    initial begin
        int limit;
        #1;
        limit = rows.size() * 40;
        repeat (limit + 4) @(posedge clk);
        $display("timeout: table not finished after %0d clock cycles, busy stuck?", limit);
        $display("Test FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

/* src/mem_top.sv */
/*
  memory subsystem, access unit plus RAM model
  CPU request signals come in as plain ports
  no latency is added at this level
*/
`timescale 1ns/100ps
`include "mem_defs.svh"

module mem_top
    import cpu_req_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               cen,
    input  logic               req,
    input  logic               wr,
    input  acc_size_t          size,
    input  ea_src_t            src,
    input  logic               da2ea,
    input  logic [`ADDR_W-1:0] pc,
    input  logic [`ADDR_W-1:0] da,
    input  logic [`ADDR_W-1:0] xsp,
    input  logic [31:0]        wdata32,
    output logic [`ADDR_W-1:0] ea,
    output logic [31:0]        mdata,
    output logic               busy
);

    mem_bus_if bus_if ();

    mem_access u_access (
        .clk     (clk),
        .rst     (rst),
        .cen     (cen),
        .req     (req),
        .wr      (wr),
        .size    (size),
        .src     (src),
        .da2ea   (da2ea),
        .pc      (pc),
        .da      (da),
        .xsp     (xsp),
        .wdata32 (wdata32),
        .ea      (ea),
        .mdata   (mdata),
        .busy    (busy),
        .bus     (bus_if.master)
    );

    word_ram u_ram (
        .clk (clk),
        .rst (rst),
        .cen (cen),
        .bus (bus_if.slave)
    );

endmodule

/* src/word_ram.sv */
/*
  byte writable RAM of 16-bit words, stands in for external memory
  combinational read, lanes written on the clock edge while cen is high
  only the low address bits are decoded, contents power up unknown
*/
`timescale 1ns/100ps
`include "mem_defs.svh"

module word_ram (
    input  logic      clk,
    input  logic      rst,
    input  logic      cen,
    mem_bus_if.slave  bus
);

    localparam int AW = $clog2(`RAM_WORDS);

    logic [`BUS_W-1:0] mem [`RAM_WORDS];
    logic [AW-1:0]     widx;

    assign widx      = bus.addr[AW:1];    // byte address to word index
    assign bus.rdata = mem[widx];

    always_ff @(posedge clk) begin
        if (cen) begin
            if (bus.we[0])
                mem[widx][7:0] <= bus.wdata[7:0];
            if (bus.we[1])
                mem[widx][15:8] <= bus.wdata[15:8];
        end
    end

    // upper bits would alias onto the same words
    a_in_range: assert property (@(posedge clk) disable iff (rst)
        (cen && |bus.we) |-> (bus.addr[`ADDR_W-1:AW+1] == '0))
        else $error("write outside RAM range at %h", bus.addr);

endmodule

/* mem/mem_access.sv */
/*
  splits CPU accesses into 16-bit bus cycles, odd addresses included
  reads always fetch four bytes, a read of the cached address is skipped
  any write invalidates the cached address
  req is only taken while busy is low, all state holds while cen is low
*/
`timescale 1ns/100ps
`include "mem_defs.svh"

module mem_access
    import cpu_req_pkg::*, bus_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               cen,
    input  logic               req,
    input  logic               wr,
    input  acc_size_t          size,
    input  ea_src_t            src,
    input  logic               da2ea,
    input  logic [`ADDR_W-1:0] pc,
    input  logic [`ADDR_W-1:0] da,
    input  logic [`ADDR_W-1:0] xsp,
    input  logic [31:0]        wdata32,
    output logic [`ADDR_W-1:0] ea,
    output logic [31:0]        mdata,
    output logic               busy,
    mem_bus_if.master          bus
);

    logic [`ADDR_W-1:0] nx_addr;    // selected request address
    logic [`ADDR_W-1:0] ca;         // cached read address
    logic [`ADDR_W-1:0] wa;         // write start address
    logic [1:0]         adelta;     // byte offset of the current bus cycle
    logic [39:0]        wdadj;      // write data moved to its lanes
    logic [23:0]        pend;       // bytes still to be written
    logic [`BUS_W-1:0]  wdata_q;
    logic [31:0]        rbuf;       // read data being assembled
    lane_we_t           we_q;
    logic               rd_q;
    bus_phase_t         phase;
    acc_size_t          sz_q;
    logic               op_wr;      // current access is a write
    logic               fin;        // last read lane is in rbuf
    logic               wr_start;
    logic               rd_start;
    logic               wr_more1;   // write needs a second bus cycle
    logic               wr_more2;   // and a third one

    always_comb begin
        case (src)
            SRC_PC: nx_addr = pc;
            SRC_DA: nx_addr = da;
            SRC_SP: nx_addr = xsp;
            SRC_EA: nx_addr = ea;
        endcase
    end

    assign wr_start = cen && req && !busy && wr;
    assign rd_start = cen && req && !busy && !wr && (nx_addr != ca);  // else skipped

    // odd start shifts everything up one lane
    assign wdadj = nx_addr[0] ? {wdata32, 8'd0} : {8'd0, wdata32};

    assign wr_more1 = (sz_q == SZ_QUAD) || (sz_q == SZ_WORD && wa[0]);
    assign wr_more2 = (sz_q == SZ_QUAD) && wa[0];

    assign bus.addr  = (op_wr ? wa : ca) + {{(`ADDR_W-2){1'b0}}, adelta};
    assign bus.wdata = wdata_q;
    assign bus.we    = we_q;
    assign bus.rd    = rd_q;

    // control
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ca     <= '1;           // first read is never a hit
            ea     <= '0;
            mdata  <= '0;
            busy   <= 1'b0;
            phase  <= PH_IDLE;
            op_wr  <= 1'b0;
            fin    <= 1'b0;
            rd_q   <= 1'b0;
            we_q   <= LANE_NONE;
            adelta <= 2'd0;
            sz_q   <= SZ_BYTE;
        end else if (cen) begin
            if (da2ea)
                ea <= da;
            if (fin) begin
                mdata <= rbuf;      // whole word at once
                fin   <= 1'b0;
                busy  <= 1'b0;
            end
            case (phase)
                PH_IDLE: begin
                    if (wr_start) begin
                        ca     <= '1;   // drop the cached read
                        op_wr  <= 1'b1;
                        sz_q   <= size;
                        adelta <= 2'd0;
                        we_q   <= {size != SZ_BYTE || nx_addr[0], !nx_addr[0]};
                        busy   <= 1'b1;
                        phase  <= PH_1;
                    end else if (rd_start) begin
                        ca     <= nx_addr;
                        op_wr  <= 1'b0;
                        adelta <= 2'd0;
                        rd_q   <= 1'b1;
                        busy   <= 1'b1;
                        phase  <= PH_1;
                    end
                end
                PH_1: begin
                    if (op_wr) begin
                        if (wr_more1) begin
                            adelta <= wa[0] ? 2'd1 : 2'd2;  // next even word
                            we_q   <= (sz_q == SZ_QUAD) ? LANE_BOTH : LANE_LO;
                            phase  <= PH_2;
                        end else begin
                            we_q   <= LANE_NONE;
                            op_wr  <= 1'b0;
                            busy   <= 1'b0;
                            phase  <= PH_IDLE;
                        end
                    end else begin
                        adelta <= ca[0] ? 2'd1 : 2'd2;
                        phase  <= PH_2;
                    end
                end
                PH_2: begin
                    if (op_wr) begin
                        if (wr_more2) begin
                            adelta <= 2'd3;
                            we_q   <= LANE_LO;      // top byte of an odd quad
                            phase  <= PH_3;
                        end else begin
                            we_q   <= LANE_NONE;
                            op_wr  <= 1'b0;
                            busy   <= 1'b0;
                            phase  <= PH_IDLE;
                        end
                    end else if (ca[0]) begin
                        adelta <= 2'd3;
                        phase  <= PH_3;
                    end else begin
                        rd_q   <= 1'b0;
                        fin    <= 1'b1;
                        phase  <= PH_IDLE;
                    end
                end
                PH_3: begin
                    we_q  <= LANE_NONE;
                    rd_q  <= 1'b0;
                    fin   <= !op_wr;
                    busy  <= !op_wr;        // reads still need the mdata update
                    op_wr <= 1'b0;
                    phase <= PH_IDLE;
                end
            endcase
        end
    end

    // payload, follows the control steps above
    always_ff @(posedge clk) begin
        if (cen) begin
            if (wr_start) begin
                wa      <= nx_addr;
                wdata_q <= wdadj[15:0];
                pend    <= wdadj[39:16];
            end else if (op_wr && phase != PH_IDLE) begin
                wdata_q <= pend[15:0];
                pend    <= pend >> 16;
            end
            if (!op_wr) begin
                case (phase)
                    PH_1: begin
                        if (ca[0])
                            rbuf[7:0] <= bus.rdata[15:8];   // odd byte of word below
                        else
                            rbuf[15:0] <= bus.rdata;
                    end
                    PH_2: begin
                        if (ca[0])
                            rbuf[23:8] <= bus.rdata;
                        else
                            rbuf[31:16] <= bus.rdata;
                    end
                    PH_3: rbuf[31:24] <= bus.rdata[7:0];
                    default: ;
                endcase
            end
        end
    end

    a_no_rd_we: assert property (@(posedge clk) disable iff (rst)
        !(bus.rd && |bus.we))
        else $error("bus read and write active together");

    // CPU must wait for busy low
    a_req_idle: assert property (@(posedge clk) disable iff (rst)
        req |-> !busy)
        else $error("req while busy");

    a_phase_bound: assert property (@(posedge clk) disable iff (rst)
        $rose(phase != PH_IDLE) |-> cen [->1:3] ##1 (phase == PH_IDLE))
        else $error("access did not finish within four cen edges");

endmodule

/* common/mem_bus_if.sv */
/*
  16-bit memory bus between the access unit and the RAM
  addr is a byte address, the slave drops its low bit
  rdata must be combinational from addr
*/
`timescale 1ns/100ps
`include "mem_defs.svh"

interface mem_bus_if
    import bus_pkg::*;
();
    logic [`ADDR_W-1:0] addr;   // byte address
    logic [`BUS_W-1:0]  wdata;
    logic [`BUS_W-1:0]  rdata;
    lane_we_t           we;     // per lane, written on the clock edge
    logic               rd;     // read cycle in progress

    modport master (
        output addr,
        output wdata,
        output we,
        output rd,
        input  rdata
    );

    modport slave (
        input  addr,
        input  wdata,
        input  we,
        input  rd,
        output rdata
    );

endinterface

/* common/bus_pkg.sv */
/*
  bus side types for the 16-bit memory bus
  lane 0 is the low byte and sits at the even address
*/
package bus_pkg;

    // one write enable per byte lane
    typedef logic [1:0] lane_we_t;

    localparam lane_we_t LANE_NONE = 2'b00;
    localparam lane_we_t LANE_LO   = 2'b01;  // even byte only
    localparam lane_we_t LANE_BOTH = 2'b11;

    // bus cycle step of the access unit, an access uses at most three
    typedef enum logic [1:0] {
        PH_IDLE = 2'd0,
        PH_1    = 2'd1,
        PH_2    = 2'd2,
        PH_3    = 2'd3
    } bus_phase_t;

endpackage

/* common/cpu_req_pkg.sv */
/*
  CPU side request types
  quad accesses are four bytes, little endian, at any byte address
  SRC_EA selects the latched effective address, not a live register
*/
package cpu_req_pkg;

    // access size of a CPU request
    typedef enum logic [1:0] {
        SZ_BYTE = 2'd0,
        SZ_WORD = 2'd1,  // two bytes
        SZ_QUAD = 2'd2   // four bytes
    } acc_size_t;

    // where the access address comes from
    typedef enum logic [1:0] {
        SRC_PC = 2'd0,   // program counter
        SRC_DA = 2'd1,   // data address from the decoder
        SRC_SP = 2'd2,   // stack pointer
        SRC_EA = 2'd3    // latched effective address
    } ea_src_t;

endpackage

/* common/mem_defs.svh */
/*
  widths and depth shared by the memory subsystem
  the RAM decodes only the low address bits, higher bits must stay zero
  BUS_W is fixed at two byte lanes, other widths are not supported
*/
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// CPU byte address
`define ADDR_W 24

// external data bus, two byte lanes
`define BUS_W 16

// RAM depth in bus words
`define RAM_WORDS 4096

`endif
